/* hdl/stream_pkg.sv */
package stream_pkg;

    // APB register map, byte offsets
    typedef enum logic [3:0] {
        REG_DATA   = 4'h0,
        REG_CTRL   = 4'h4,
        REG_GAP    = 4'h8,
        REG_STATUS = 4'hC
    } reg_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        GAP
    } burst_state_t;

    // Status word bit positions
    localparam int STAT_EMPTY     = 0;
    localparam int STAT_FULL      = 1;
    localparam int STAT_BUSY      = 2;
    localparam int STAT_OVF       = 3; // Sticky, cleared by status write
    localparam int STAT_LEVEL_LSB = 8;

    // Field widths
    localparam int LEN_W = 8;
    localparam int GAP_W = 8;

endpackage

/* hdl/apb_regs.sv */
`timescale 1ns/1ps

module apb_regs #(
    parameter int DATA_WIDTH = 32,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                          clk_in,
    input  logic                          rst_n,
    input  logic [3:0]                    paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [DATA_WIDTH-1:0]         pwdata,
    output logic [DATA_WIDTH-1:0]         prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          push,
    output logic [DATA_WIDTH-1:0]         push_data,
    input  logic                          full,
    input  logic                          empty,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0] level,
    output logic                          start,
    output logic [stream_pkg::LEN_W-1:0]  burst_len,
    output logic [stream_pkg::GAP_W-1:0]  gap_len,
    input  logic                          busy
);

    localparam int LVL_W   = $clog2(FIFO_DEPTH + 1);
    localparam int LEN_LSB = 8; // Length field in REG_CTRL

    stream_pkg::reg_addr_t addr;
    logic                  wr_access;
    logic                  rd_access;
    logic                  data_wr;
    logic                  ctrl_wr;
    logic                  gap_wr;
    logic                  stat_wr;
    logic                  data_err;
    logic                  ctrl_err;
    logic                  ovf;
    logic [DATA_WIDTH-1:0] status;

    assign addr      = stream_pkg::reg_addr_t'(paddr);
    assign wr_access = psel && penable && pwrite;
    assign rd_access = psel && !pwrite;

    assign data_wr = wr_access && (addr == stream_pkg::REG_DATA);
    assign ctrl_wr = wr_access && (addr == stream_pkg::REG_CTRL);
    assign gap_wr  = wr_access && (addr == stream_pkg::REG_GAP);
    assign stat_wr = wr_access && (addr == stream_pkg::REG_STATUS);

    // Illegal writes are dropped and flagged
    assign data_err = data_wr && full;
    assign ctrl_err = ctrl_wr && pwdata[0] && busy;
    assign pslverr  = data_err || ctrl_err;
    assign pready   = 1'b1;

    assign push      = data_wr && !full;
    assign push_data = pwdata;

    always_comb begin
        status                                        = '0;
        status[stream_pkg::STAT_EMPTY]                = empty;
        status[stream_pkg::STAT_FULL]                 = full;
        status[stream_pkg::STAT_BUSY]                 = busy;
        status[stream_pkg::STAT_OVF]                  = ovf;
        status[stream_pkg::STAT_LEVEL_LSB +: LVL_W]   = level;
    end

    always_comb begin
        prdata = '0;
        if (rd_access) begin
            case (addr)
                stream_pkg::REG_CTRL: begin
                    prdata[LEN_LSB +: stream_pkg::LEN_W] = burst_len;
                end
                stream_pkg::REG_GAP: begin
                    prdata[stream_pkg::GAP_W-1:0] = gap_len;
                end
                stream_pkg::REG_STATUS: begin
                    prdata = status;
                end
                default: begin
                    prdata = '0; // Data port is write only
                end
            endcase
        end
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            start     <= 1'b0;
            burst_len <= '0;
            gap_len   <= '0;
            ovf       <= 1'b0;
        end else begin
            start <= ctrl_wr && pwdata[0] && !ctrl_err; // One cycle pulse
            if (ctrl_wr && !ctrl_err) begin
                burst_len <= pwdata[LEN_LSB +: stream_pkg::LEN_W];
            end
            if (gap_wr) begin
                gap_len <= pwdata[stream_pkg::GAP_W-1:0];
            end
            if (data_err) begin
                ovf <= 1'b1;
            end else if (stat_wr) begin
                ovf <= 1'b0;
            end
        end
    end

endmodule

/* hdl/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                            clk_in,
    input  logic                            rst_n,
    input  logic                            push,
    input  logic [DATA_WIDTH-1:0]           push_data,
    output logic                            full,
    input  logic                            pop,
    output logic [DATA_WIDTH-1:0]           head_data,
    output logic                            empty,
    output logic [$clog2(FIFO_DEPTH+1)-1:0] level
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [0:FIFO_DEPTH-1];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  do_push;
    logic                  do_pop;

    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop); // Full plus pop frees a slot

    assign full      = (count == CNT_W'(FIFO_DEPTH));
    assign empty     = (count == '0);
    assign level     = count;
    assign head_data = mem[rd_ptr]; // Show-ahead

    always_ff @(posedge clk_in) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hdl/burst_fsm.sv */
`timescale 1ns/1ps

module burst_fsm (
    input  logic                         clk_in,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic [stream_pkg::LEN_W-1:0] burst_len,
    input  logic [stream_pkg::GAP_W-1:0] gap_len,
    output logic                         busy,
    input  logic                         empty,
    output logic                         pop,
    output logic                         out_valid,
    input  logic                         out_ready,
    output logic                         load_beats,
    output logic                         load_gap,
    output logic                         beat_done,
    output logic                         gap_tick,
    input  logic                         gap_zero,
    input  logic                         last_beat
);

    stream_pkg::burst_state_t state;
    stream_pkg::burst_state_t state_nxt;
    logic                     hs;

    assign out_valid = (state == stream_pkg::SEND) && !empty;
    assign hs        = out_valid && out_ready;
    assign busy      = (state != stream_pkg::IDLE);

    assign pop        = hs;
    assign beat_done  = hs;
    assign load_beats = (state == stream_pkg::IDLE) && start;
    assign load_gap   = hs && !last_beat;
    assign gap_tick   = (state == stream_pkg::GAP);

    always_comb begin
        state_nxt = state;
        case (state)
            stream_pkg::IDLE: begin
                if (start) begin
                    state_nxt = stream_pkg::SEND;
                end
            end
            stream_pkg::SEND: begin
                if (hs) begin
                    if (last_beat) begin
                        state_nxt = stream_pkg::IDLE;
                    end else if (gap_len != '0) begin
                        state_nxt = stream_pkg::GAP;
                    end
                end
            end
            stream_pkg::GAP: begin
                if (gap_zero) begin
                    state_nxt = stream_pkg::SEND;
                end
            end
            default: begin
                state_nxt = stream_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            state <= stream_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

/* hdl/pace_timer.sv */
`timescale 1ns/1ps

module pace_timer (
    input  logic                         clk_in,
    input  logic                         rst_n,
    input  logic                         load_beats,
    input  logic [stream_pkg::LEN_W-1:0] burst_len,
    input  logic                         load_gap,
    input  logic [stream_pkg::GAP_W-1:0] gap_len,
    input  logic                         beat_done,
    input  logic                         gap_tick,
    output logic                         last_beat,
    output logic                         gap_zero
);

    logic [stream_pkg::LEN_W:0]   beats_left; // One extra bit to hold 256
    logic [stream_pkg::GAP_W-1:0] gap_left;

    assign last_beat = (beats_left == 1);
    assign gap_zero  = (gap_left <= 1); // Leaves GAP after exactly gap cycles

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            beats_left <= '0;
            gap_left   <= '0;
        end else begin
            if (load_beats) begin
                beats_left <= (burst_len == '0) ? (1 << stream_pkg::LEN_W) : {1'b0, burst_len};
            end else if (beat_done && beats_left != '0) begin
                beats_left <= beats_left - 1'b1;
            end
            if (load_gap) begin
                gap_left <= gap_len;
            end else if (gap_tick && gap_left != '0) begin
                gap_left <= gap_left - 1'b1;
            end
        end
    end

endmodule

/* hdl/stream_tx_top.sv */
`timescale 1ns/1ps

module stream_tx_top #(
    parameter int DATA_WIDTH = 32, // At least 32 for the control word
    parameter int FIFO_DEPTH = 16
) (
    input  logic                  clk_in,
    input  logic                  rst_n,
    input  logic [3:0]            paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [DATA_WIDTH-1:0] pwdata,
    output logic [DATA_WIDTH-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  out_valid,
    output logic [DATA_WIDTH-1:0] out_data,
    input  logic                  out_ready
);

    localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

    logic                         push;
    logic [DATA_WIDTH-1:0]        push_data;
    logic                         full;
    logic                         empty;
    logic [LVL_W-1:0]             level;
    logic                         pop;
    logic                         start;
    logic                         busy;
    logic [stream_pkg::LEN_W-1:0] burst_len;
    logic [stream_pkg::GAP_W-1:0] gap_len;
    logic                         load_beats;
    logic                         load_gap;
    logic                         beat_done;
    logic                         gap_tick;
    logic                         gap_zero;
    logic                         last_beat;

    apb_regs #(
        .DATA_WIDTH (DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) apb_regs_i (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .empty     (empty),
        .level     (level),
        .start     (start),
        .burst_len (burst_len),
        .gap_len   (gap_len),
        .busy      (busy)
    );

    sync_fifo #(
        .DATA_WIDTH (DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) sync_fifo_i (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .pop       (pop),
        .head_data (out_data), // Head word drives the stream directly
        .empty     (empty),
        .level     (level)
    );

    burst_fsm burst_fsm_i (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .start      (start),
        .burst_len  (burst_len),
        .gap_len    (gap_len),
        .busy       (busy),
        .empty      (empty),
        .pop        (pop),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .load_beats (load_beats),
        .load_gap   (load_gap),
        .beat_done  (beat_done),
        .gap_tick   (gap_tick),
        .gap_zero   (gap_zero),
        .last_beat  (last_beat)
    );

    pace_timer pace_timer_i (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .load_beats (load_beats),
        .burst_len  (burst_len),
        .load_gap   (load_gap),
        .gap_len    (gap_len),
        .beat_done  (beat_done),
        .gap_tick   (gap_tick),
        .last_beat  (last_beat),
        .gap_zero   (gap_zero)
    );

endmodule

/* testbench/tb_stream_tx.sv */
`timescale 1ns/1ps

module tb_stream_tx;

    localparam int DATA_WIDTH = 32;
    localparam int FIFO_DEPTH = 16;
    localparam int LVL_W      = $clog2(FIFO_DEPTH + 1);
    localparam int NUM_BURSTS = 12;
    localparam int MAX_LEN    = FIFO_DEPTH;
    localparam int MAX_GAP    = 7;
    localparam int MAX_POLLS  = 400;
    // Random bursts plus three directed ones, times 3 for APB overhead and stalls
    localparam int WD_CYCLES  = 3 * (NUM_BURSTS + 3) * (MAX_LEN * (MAX_GAP + 2) + 64);

    logic                  clk_in;
    logic                  rst_n;
    logic [3:0]            paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [DATA_WIDTH-1:0] pwdata;
    logic [DATA_WIDTH-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  out_valid;
    logic [DATA_WIDTH-1:0] out_data;
    logic                  out_ready;

    integer                seed = 32'h78c49042;
    integer                ready_seed = 32'h78c49042; // Own sequence for out_ready
    logic [DATA_WIDTH-1:0] model_q[$]; // Expected FIFO contents
    logic                  model_ovf;
    int                    errors;
    int                    cur_gap;
    int                    hs_count;
    int                    cycle;
    int                    last_hs;
    logic                  prev_valid;
    logic                  prev_ready;
    logic [DATA_WIDTH-1:0] prev_data;

    stream_tx_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) stream_tx_top_i (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            stop_run($sformatf("ERR t=%0t %s actual=%h expected=%h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk_in);
        psel    <= 1'b1; // Setup phase
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk_in);
        penable <= 1'b1;
        @(negedge clk_in);
        err = pslverr;
        check("pready on write", pready, 1'b1);
        @(posedge clk_in); // Access edge
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        @(posedge clk_in);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk_in);
        penable <= 1'b1;
        @(negedge clk_in);
        data = prdata;
        check("pready on read", pready, 1'b1);
        @(posedge clk_in);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic push_word(input logic [31:0] data);
        logic err;
        logic exp_err;
        exp_err = (model_q.size() == FIFO_DEPTH);
        apb_write(stream_pkg::REG_DATA, data, err);
        check("pslverr on data write", err, exp_err);
        if (exp_err) begin
            model_ovf = 1'b1; // Word dropped
        end else begin
            model_q.push_back(data);
        end
    endtask

    // Only valid while no burst runs
    task automatic check_status();
        logic [31:0] st;
        apb_read(stream_pkg::REG_STATUS, st);
        check("status.empty", st[stream_pkg::STAT_EMPTY], model_q.size() == 0);
        check("status.full", st[stream_pkg::STAT_FULL], model_q.size() == FIFO_DEPTH);
        check("status.busy", st[stream_pkg::STAT_BUSY], 1'b0);
        check("status.ovf", st[stream_pkg::STAT_OVF], model_ovf);
        check("status.level", st[stream_pkg::STAT_LEVEL_LSB +: LVL_W], model_q.size());
    endtask

    task automatic start_burst(input int len, input int gap);
        logic err;
        apb_write(stream_pkg::REG_GAP, gap, err);
        check("pslverr on gap write", err, 1'b0);
        cur_gap  = gap;
        hs_count = 0;
        last_hs  = -1;
        apb_write(stream_pkg::REG_CTRL, (len << 8) | 1, err);
        check("pslverr on start", err, 1'b0);
    endtask

    task automatic wait_idle();
        logic [31:0]              st;
        stream_pkg::burst_state_t fsm_state;
        int                       polls;
        polls = 0;
        do begin
            apb_read(stream_pkg::REG_STATUS, st);
            polls++;
        end while (st[stream_pkg::STAT_BUSY] && polls < MAX_POLLS);
        if (st[stream_pkg::STAT_BUSY]) begin
            fsm_state = stream_tx_top_i.burst_fsm_i.state;
            stop_run($sformatf("Burst did not finish, controller stuck in %s",
                               fsm_state.name()));
        end
    endtask

    task automatic run_burst(input int len, input int gap);
        start_burst(len, gap);
        wait_idle();
        check("handshake count", hs_count, len);
        check_status();
    endtask

    always @(posedge clk_in) begin
        out_ready <= (($random(ready_seed) & 3) != 0); // Ready about 3 cycles in 4
    end

    // Stream monitor, samples mid cycle
    always @(negedge clk_in) begin
        cycle++;
        if (rst_n) begin
            if (prev_valid && !prev_ready) begin
                check("out_valid held", out_valid, 1'b1);
                check("out_data held", out_data, prev_data);
            end
            if (out_valid && out_ready) begin
                if (model_q.size() == 0) begin
                    stop_run("Stream handshake while no word was expected");
                end else begin
                    check("out_data", out_data, model_q.pop_front());
                    if (last_hs >= 0) begin
                        check("beat spacing ok", (cycle - last_hs) >= cur_gap + 1, 1'b1);
                    end
                    last_hs = cycle;
                    hs_count++;
                end
            end
        end
        prev_valid = out_valid;
        prev_ready = out_ready;
        prev_data  = out_data;
    end

    initial begin
        #(WD_CYCLES * 8);
        stop_run("Watchdog expired, the run took too long");
    end

    initial begin
        logic [31:0] rd;
        logic        err;
        int          n_words;
        int          len;
        int          gap;
        rst_n     = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        out_ready = 1'b0;
        model_ovf = 1'b0;
        errors    = 0;
        cycle     = 0;
        last_hs   = -1;
        hs_count  = 0;
        cur_gap   = 0;
        repeat (2) @(posedge clk_in);
        rst_n <= 1'b1;
        @(negedge clk_in);
        check("out_valid after reset", out_valid, 1'b0);
        apb_read(stream_pkg::REG_STATUS, rd);
        check("status after reset", rd, 32'h1 << stream_pkg::STAT_EMPTY);

        for (int b = 0; b < NUM_BURSTS; b++) begin
            n_words = ($random(seed) & 32'h7fff_ffff) % (FIFO_DEPTH - model_q.size() + 1);
            if (model_q.size() + n_words == 0) begin
                n_words = 1;
            end
            for (int i = 0; i < n_words; i++) begin
                push_word($random(seed));
            end
            check_status();
            len = 1 + (($random(seed) & 32'h7fff_ffff) % model_q.size());
            gap = ($random(seed) & 32'h7fff_ffff) % (MAX_GAP + 1);
            run_burst(len, gap);
        end

        // Overflow on a full FIFO
        while (model_q.size() < FIFO_DEPTH) begin
            push_word($random(seed));
        end
        check_status();
        push_word(32'hdead_beef);
        check_status();
        apb_write(stream_pkg::REG_STATUS, 32'h0, err);
        check("pslverr on status write", err, 1'b0);
        model_ovf = 1'b0;
        check_status();
        run_burst(FIFO_DEPTH, 0);

        // Starved burst, and a second start while busy
        start_burst(4, 2);
        apb_write(stream_pkg::REG_CTRL, (8 << 8) | 1, err);
        check("pslverr on start while busy", err, 1'b1);
        apb_read(stream_pkg::REG_STATUS, rd);
        check("status.busy while starved", rd[stream_pkg::STAT_BUSY], 1'b1);
        repeat (6) begin
            @(negedge clk_in);
            check("out_valid while starved", out_valid, 1'b0);
        end
        push_word($random(seed));
        push_word($random(seed));
        repeat (20) @(posedge clk_in);
        push_word($random(seed));
        push_word($random(seed));
        wait_idle();
        check("handshake count", hs_count, 4);
        check_status();

        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* src.f */
hdl/stream_pkg.sv
hdl/apb_regs.sv
hdl/sync_fifo.sv
hdl/burst_fsm.sv
hdl/pace_timer.sv
hdl/stream_tx_top.sv
testbench/tb_stream_tx.sv

/* Bender.yml */
package:
  name: stream_tx

sources:
  - hdl/stream_pkg.sv
  - hdl/apb_regs.sv
  - hdl/sync_fifo.sv
  - hdl/burst_fsm.sv
  - hdl/pace_timer.sv
  - hdl/stream_tx_top.sv
  - target: test
    files:
      - testbench/tb_stream_tx.sv
